//--- design/uartPkg.sv
package uartPkg;

	// Register offsets seen by the bus master, one 32-bit word each
	localparam logic [23:0] addrTxFlag   = 24'h00_0000;
	localparam logic [23:0] addrRxFlag   = 24'h00_0004;
	localparam logic [23:0] addrTxData   = 24'h00_0008;
	localparam logic [23:0] addrRxData   = 24'h00_000C;
	localparam logic [23:0] addrBaudRate = 24'h00_0010;

	localparam int oversample = 16; // Baud ticks per serial bit

	// One bus request as driven by the master and carried down the wait-state pipeline
	typedef struct packed {
		logic enable;
		logic read;
		logic write;
		logic [23:0] address;
		logic [31:0] writeData;
	} busRequest;

	// Stored register state; the transmit flag is the live busy level and is not stored
	typedef struct packed {
		logic rxFlag;
		logic [7:0] rxData;
		logic [31:0] txData;
		logic [31:0] baudRate;
	} regFile;

	typedef enum logic [1:0] {
		txIdle,
		txStart,
		txData,
		txStop
	} txState;

	typedef enum logic [1:0] {
		rxIdle,
		rxStart,
		rxData,
		rxStop
	} rxState;

endpackage

//--- design/uartRegs.sv
`timescale 1ns/1ps

module uartRegs #(
	parameter int waitStates = 2
) (
	input logic clock,
	input logic reset,
	input uartPkg::busRequest request,
	output logic [31:0] readData,
	output logic ready,
	output logic [15:0] baudDivisor,
	output logic txStart,
	output logic [7:0] txByte,
	input logic txBusy,
	input logic rxValid,
	input logic [7:0] rxByte
);

	uartPkg::busRequest pipe [waitStates:0];
	uartPkg::busRequest last;
	uartPkg::regFile regs;
	logic [31:0] readMux;
	logic lastWrite;
	logic lastRead;
	logic firstRead;

	assign last = pipe[waitStates]; // Request that has waited out its wait states
	assign lastWrite = last.enable && last.write;
	assign lastRead = last.enable && last.read;
	assign firstRead = pipe[0].enable && pipe[0].read;

	assign baudDivisor = regs.baudRate[15:0];
	assign txByte = regs.txData[7:0];

	// An accepted request moves one stage down the pipeline per clock
	always_ff @(posedge clock) begin
		if (reset) begin
			pipe <= '{default: '0};
		end else begin
			pipe[0] <= ready ? request : '0; // Nothing is accepted while a read is pending
			for (int i = 1; i <= waitStates; i++) begin
				pipe[i] <= pipe[i - 1];
			end
		end
	end

	always_comb begin
		case (last.address)
			uartPkg::addrTxFlag: begin
				readMux = {31'b0, txBusy};
			end
			uartPkg::addrRxFlag: begin
				readMux = {31'b0, regs.rxFlag};
			end
			uartPkg::addrTxData: begin
				readMux = regs.txData;
			end
			uartPkg::addrRxData: begin
				readMux = {24'b0, regs.rxData};
			end
			uartPkg::addrBaudRate: begin
				readMux = regs.baudRate;
			end
			default: begin
				readMux = '0;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			regs <= '0;
			readData <= '0;
			ready <= 1'b1;
			txStart <= 1'b0;
		end else begin
			txStart <= 1'b0;
			if (lastWrite) begin
				case (last.address)
					uartPkg::addrTxFlag: begin
						// Dropped while a frame is on the line or just starting
						txStart <= last.writeData[0] && !txBusy && !txStart;
					end
					uartPkg::addrRxFlag: begin
						if (!last.writeData[0]) begin
							regs.rxFlag <= 1'b0;
						end
					end
					uartPkg::addrTxData: begin
						regs.txData <= last.writeData;
					end
					uartPkg::addrBaudRate: begin
						regs.baudRate <= last.writeData;
					end
					default: begin
					end
				endcase
			end
			// A new byte comes after the clear so that the set wins on a shared edge
			if (rxValid) begin
				regs.rxFlag <= 1'b1;
				regs.rxData <= rxByte;
			end
			if (firstRead) begin
				ready <= 1'b0;
			end else if (lastRead) begin
				ready <= 1'b1;
			end
			if (lastRead) begin
				readData <= readMux;
			end
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		$fell(ready) |-> ##[1:waitStates] ready)
		else $error("Bus ready held low longer than the wait states");

	assert property (@(posedge clock) disable iff (reset) txStart |-> !txBusy)
		else $error("Transmit start issued while the transmitter is busy");

endmodule

//--- design/baudGen.sv
`timescale 1ns/1ps

module baudGen (
	input logic clock,
	input logic reset,
	input logic [15:0] baudDivisor,
	output logic tick
);

	logic [15:0] count;
	logic [15:0] lastDivisor;

	// One tick every baudDivisor+1 clocks
	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
			lastDivisor <= '0;
			tick <= 1'b0;
		end else begin
			lastDivisor <= baudDivisor;
			if (baudDivisor != lastDivisor) begin
				count <= baudDivisor; // Restart at the new rate
				tick <= 1'b0;
			end else if (count == '0) begin
				count <= baudDivisor;
				tick <= 1'b1;
			end else begin
				count <= count - 16'd1;
				tick <= 1'b0;
			end
		end
	end

endmodule

//--- design/uartTx.sv
`timescale 1ns/1ps

module uartTx (
	input logic clock,
	input logic reset,
	input logic tick,
	input logic txStart,
	input logic [7:0] txByte,
	output logic txd,
	output logic txBusy
);

	uartPkg::txState state;
	logic [3:0] tickCount;
	logic [2:0] bitIndex;
	logic [7:0] shifter;
	logic bitDone;

	assign bitDone = tick && (tickCount == 4'(uartPkg::oversample - 1));
	assign txBusy = (state != uartPkg::txIdle);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= uartPkg::txIdle;
			tickCount <= '0;
			bitIndex <= '0;
			txd <= 1'b1;
		end else begin
			if (tick) begin
				tickCount <= tickCount + 4'd1; // Wraps at the end of each bit
			end
			case (state)
				uartPkg::txIdle: begin
					tickCount <= '0;
					if (txStart) begin
						state <= uartPkg::txStart;
						txd <= 1'b0;
					end
				end
				uartPkg::txStart: begin
					if (bitDone) begin
						state <= uartPkg::txData;
						bitIndex <= '0;
						txd <= shifter[0];
					end
				end
				uartPkg::txData: begin
					if (bitDone) begin
						if (bitIndex == 3'd7) begin
							state <= uartPkg::txStop;
							txd <= 1'b1;
						end else begin
							bitIndex <= bitIndex + 3'd1;
							txd <= shifter[1]; // Next bit, the shifter moves on at this edge
						end
					end
				end
				uartPkg::txStop: begin
					if (bitDone) begin
						state <= uartPkg::txIdle;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == uartPkg::txIdle && txStart) begin
			shifter <= txByte;
		end else if (state == uartPkg::txData && bitDone) begin
			shifter <= shifter >> 1;
		end
	end

	assert property (@(posedge clock) disable iff (reset) state == uartPkg::txIdle |-> txd)
		else $error("Transmit line not idle high between frames");

endmodule

//--- design/uartRx.sv
`timescale 1ns/1ps

module uartRx (
	input logic clock,
	input logic reset,
	input logic tick,
	input logic rxd,
	output logic rxValid,
	output logic [7:0] rxByte
);

	uartPkg::rxState state;
	logic [1:0] rxSync;
	logic rxdLast;
	logic rxBit;
	logic fallingEdge;
	logic [3:0] tickCount;
	logic [2:0] bitIndex;
	logic [7:0] shifter;
	logic bitDone;
	logic halfDone;

	assign rxBit = rxSync[1];
	assign fallingEdge = rxdLast && !rxBit;
	assign bitDone = tick && (tickCount == 4'(uartPkg::oversample - 1));
	assign halfDone = tick && (tickCount == 4'(uartPkg::oversample / 2 - 1));

	always_ff @(posedge clock) begin
		if (reset) begin
			rxSync <= 2'b11; // Line idles high
			rxdLast <= 1'b1;
			state <= uartPkg::rxIdle;
			tickCount <= '0;
			bitIndex <= '0;
			rxValid <= 1'b0;
		end else begin
			rxSync <= {rxSync[0], rxd};
			rxdLast <= rxBit;
			rxValid <= 1'b0;
			if (tick) begin
				tickCount <= tickCount + 4'd1;
			end
			case (state)
				uartPkg::rxIdle: begin
					tickCount <= '0;
					if (fallingEdge) begin
						state <= uartPkg::rxStart;
					end
				end
				uartPkg::rxStart: begin
					if (halfDone) begin
						tickCount <= '0; // Later samples land at bit centres
						if (!rxBit) begin
							state <= uartPkg::rxData;
							bitIndex <= '0;
						end else begin
							state <= uartPkg::rxIdle; // A glitch and not a start bit
						end
					end
				end
				uartPkg::rxData: begin
					if (bitDone) begin
						if (bitIndex == 3'd7) begin
							state <= uartPkg::rxStop;
						end else begin
							bitIndex <= bitIndex + 3'd1;
						end
					end
				end
				uartPkg::rxStop: begin
					if (bitDone) begin
						state <= uartPkg::rxIdle;
						rxValid <= rxBit; // Framing error drops the byte
					end
				end
			endcase
		end
	end

	// Data bits arrive LSB first
	always_ff @(posedge clock) begin
		if (state == uartPkg::rxData && bitDone) begin
			shifter <= {rxBit, shifter[7:1]};
		end
		if (state == uartPkg::rxStop && bitDone && rxBit) begin
			rxByte <= shifter;
		end
	end

	assert property (@(posedge clock) disable iff (reset) rxValid |=> !rxValid)
		else $error("Receive valid held for more than one cycle");

endmodule

//--- design/uartTop.sv
`timescale 1ns/1ps

module uartTop #(
	parameter int waitStates = 2
) (
	input logic clock,
	input logic reset,
	input uartPkg::busRequest request,
	output logic [31:0] readData,
	output logic ready,
	output logic txd,
	input logic rxd
);

	logic [15:0] baudDivisor;
	logic tick;
	logic txStart;
	logic [7:0] txByte;
	logic txBusy;
	logic rxValid;
	logic [7:0] rxByte;

	uartRegs #(
		.waitStates(waitStates)
	) regBlock (
		.clock(clock),
		.reset(reset),
		.request(request),
		.readData(readData),
		.ready(ready),
		.baudDivisor(baudDivisor),
		.txStart(txStart),
		.txByte(txByte),
		.txBusy(txBusy),
		.rxValid(rxValid),
		.rxByte(rxByte)
	);

	baudGen baudTicks (
		.clock(clock),
		.reset(reset),
		.baudDivisor(baudDivisor),
		.tick(tick)
	);

	uartTx transmitter (
		.clock(clock),
		.reset(reset),
		.tick(tick),
		.txStart(txStart),
		.txByte(txByte),
		.txd(txd),
		.txBusy(txBusy)
	);

	uartRx receiver (
		.clock(clock),
		.reset(reset),
		.tick(tick),
		.rxd(rxd),
		.rxValid(rxValid),
		.rxByte(rxByte)
	);

endmodule

//--- bench/uartTopTb.sv
`timescale 1ns/1ps

module uartTopTb;

	localparam int waitStates = 2;
	localparam int readyLimit = 20; // Cycles allowed for ready to change
	localparam int pollLimit = 1000; // Reads allowed before a poll gives up

	typedef enum logic [1:0] {
		opWrite,
		opRead,
		opPoll
	} opKind;

	typedef struct packed {
		logic [2:0] behavior;
		opKind kind;
		logic [23:0] address;
		logic [31:0] writeData;
		logic [31:0] expected;
	} tableEntry;

	logic clock;
	logic reset;
	uartPkg::busRequest request;
	logic [31:0] readData;
	logic ready;
	logic serialLine; // Loopback from txd to rxd

	tableEntry opTable [$];
	string behaviorName [1:6];
	logic [2:0] currentBehavior;
	int errorCount;
	int behaviorStartErrors;
	int passCount;
	int failCount;
	logic [7:0] txShadow;
	logic [15:0] lineDivisor;

	uartTop #(
		.waitStates(waitStates)
	) DUT (
		.clock(clock),
		.reset(reset),
		.request(request),
		.readData(readData),
		.ready(ready),
		.txd(serialLine),
		.rxd(serialLine)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#50 clock = ~clock;
		end
	end

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
			errorCount++;
		end
	endtask

	// Decodes each frame on txd at its bit centres
	initial begin
		logic [7:0] lineByte;
		logic [7:0] sentByte;
		int bitClocks;
		forever begin
			@(negedge serialLine);
			if (!reset) begin
				sentByte = txShadow;
				bitClocks = 16 * (lineDivisor + 1);
				repeat (bitClocks / 2) @(negedge clock);
				checkValue(serialLine, 1'b0, "Start bit on txd");
				for (int i = 0; i < 8; i++) begin
					repeat (bitClocks) @(negedge clock);
					lineByte[i] = serialLine;
				end
				repeat (bitClocks) @(negedge clock);
				checkValue(serialLine, 1'b1, "Stop bit on txd");
				checkValue(lineByte, sentByte, "Byte on txd");
			end
		end
	end

	task automatic addOp(input opKind kind, input logic [23:0] address,
		input logic [31:0] writeData, input logic [31:0] expected);
		opTable.push_back('{currentBehavior, kind, address, writeData, expected});
	endtask

	// All bus tasks start and return on a falling edge
	task automatic waitReady();
		int cycles;
		cycles = 0;
		while (!ready && cycles < readyLimit) begin
			@(negedge clock);
			cycles++;
		end
		if (!ready) begin
			$display("The bus stayed busy too long to offer a request at %0t ns", $time);
			errorCount++;
		end
	endtask

	task automatic busWrite(input logic [23:0] address, input logic [31:0] data);
		waitReady();
		request = '{enable: 1'b1, read: 1'b0, write: 1'b1, address: address, writeData: data};
		@(negedge clock);
		request = '0;
	endtask

	task automatic busRead(input logic [23:0] address, output logic [31:0] data);
		int cycles;
		int lowCycles;
		waitReady();
		request = '{enable: 1'b1, read: 1'b1, write: 1'b0, address: address, writeData: '0};
		@(negedge clock);
		request = '0;
		cycles = 0;
		while (ready && cycles < readyLimit) begin
			@(negedge clock);
			cycles++;
		end
		if (ready) begin
			$display("The bus never dropped ready for a read at %0t ns", $time);
			errorCount++;
		end
		lowCycles = 0;
		while (!ready && lowCycles < readyLimit) begin
			@(negedge clock);
			lowCycles++;
		end
		checkValue(lowCycles, waitStates, "Ready low cycle count");
		data = readData;
	endtask

	task automatic pollUntil(input logic [23:0] address, input logic [31:0] expected);
		logic [31:0] value;
		int attempts;
		attempts = 0;
		busRead(address, value);
		while (value !== expected && attempts < pollLimit) begin
			busRead(address, value);
			attempts++;
		end
		if (value !== expected) begin
			$display("Register %h never read %h within %0d polls, gave up at %0t ns",
				address, expected, pollLimit, $time);
			errorCount++;
		end
	endtask

	task automatic reportBehavior(input logic [2:0] behavior);
		if (errorCount == behaviorStartErrors) begin
			passCount++;
			$display("Behavior %0d, %s: pass", behavior, behaviorName[behavior]);
		end else begin
			failCount++;
			$display("Behavior %0d, %s: fail", behavior, behaviorName[behavior]);
		end
		behaviorStartErrors = errorCount;
	endtask

	initial begin
		logic [31:0] baudValue;
		logic [31:0] txValue;
		logic [31:0] junkValue;
		logic [7:0] byteA;
		logic [7:0] byteB;
		logic [7:0] byteC;
		logic [7:0] byteD;
		logic [31:0] value;
		tableEntry entry;
		reset = 1'b1;
		request = '0;
		errorCount = 0;
		behaviorStartErrors = 0;
		passCount = 0;
		failCount = 0;
		txShadow = '0;
		lineDivisor = '0;
		void'($urandom(7933));
		baudValue = $urandom();
		txValue = $urandom();
		junkValue = $urandom();
		byteA = $urandom();
		byteB = $urandom();
		if (byteB == byteA) begin
			byteB = ~byteA;
		end
		byteC = $urandom();
		byteD = ~byteC; // Differs from the byte already on the line
		behaviorName[1] = "reset values";
		behaviorName[2] = "register read-back";
		behaviorName[3] = "read wait states";
		behaviorName[4] = "loopback frame";
		behaviorName[5] = "receive flag clear and second frame";
		behaviorName[6] = "start while busy is dropped";

		currentBehavior = 3'd1;
		addOp(opRead, uartPkg::addrTxFlag, '0, '0);
		addOp(opRead, uartPkg::addrRxFlag, '0, '0);
		addOp(opRead, uartPkg::addrTxData, '0, '0);
		addOp(opRead, uartPkg::addrRxData, '0, '0);
		addOp(opRead, uartPkg::addrBaudRate, '0, '0);
		addOp(opRead, 24'h00_0014, '0, '0); // First unmapped word
		currentBehavior = 3'd2;
		addOp(opWrite, uartPkg::addrBaudRate, baudValue, '0);
		addOp(opRead, uartPkg::addrBaudRate, '0, baudValue);
		addOp(opWrite, uartPkg::addrTxData, txValue, '0);
		addOp(opRead, uartPkg::addrTxData, '0, txValue);
		addOp(opWrite, uartPkg::addrRxData, junkValue, '0);
		addOp(opRead, uartPkg::addrRxData, '0, '0);
		currentBehavior = 3'd3;
		addOp(opRead, uartPkg::addrBaudRate, '0, baudValue);
		addOp(opRead, uartPkg::addrTxData, '0, txValue);
		addOp(opRead, 24'h00_0100, '0, '0);
		currentBehavior = 3'd4;
		addOp(opWrite, uartPkg::addrBaudRate, 32'd3, '0);
		addOp(opWrite, uartPkg::addrTxData, {24'b0, byteA}, '0);
		addOp(opWrite, uartPkg::addrTxFlag, 32'd1, '0);
		addOp(opPoll, uartPkg::addrTxFlag, '0, 32'd1);
		addOp(opPoll, uartPkg::addrTxFlag, '0, 32'd0);
		addOp(opPoll, uartPkg::addrRxFlag, '0, 32'd1);
		addOp(opRead, uartPkg::addrRxData, '0, {24'b0, byteA});
		currentBehavior = 3'd5;
		addOp(opWrite, uartPkg::addrRxFlag, 32'd0, '0);
		addOp(opRead, uartPkg::addrRxFlag, '0, 32'd0);
		addOp(opRead, uartPkg::addrRxData, '0, {24'b0, byteA});
		addOp(opWrite, uartPkg::addrBaudRate, 32'd5, '0);
		addOp(opWrite, uartPkg::addrTxData, {24'b0, byteB}, '0);
		addOp(opWrite, uartPkg::addrTxFlag, 32'd1, '0);
		addOp(opPoll, uartPkg::addrTxFlag, '0, 32'd1);
		addOp(opPoll, uartPkg::addrTxFlag, '0, 32'd0);
		addOp(opPoll, uartPkg::addrRxFlag, '0, 32'd1);
		addOp(opRead, uartPkg::addrRxData, '0, {24'b0, byteB});
		currentBehavior = 3'd6;
		addOp(opWrite, uartPkg::addrRxFlag, 32'd0, '0);
		addOp(opWrite, uartPkg::addrTxData, {24'b0, byteC}, '0);
		addOp(opWrite, uartPkg::addrTxFlag, 32'd1, '0);
		addOp(opPoll, uartPkg::addrTxFlag, '0, 32'd1);
		addOp(opWrite, uartPkg::addrTxData, {24'b0, byteD}, '0);
		addOp(opWrite, uartPkg::addrTxFlag, 32'd1, '0); // Lands while the frame is still going
		addOp(opRead, uartPkg::addrTxFlag, '0, 32'd1);
		addOp(opPoll, uartPkg::addrTxFlag, '0, 32'd0);
		addOp(opPoll, uartPkg::addrRxFlag, '0, 32'd1);
		addOp(opRead, uartPkg::addrRxData, '0, {24'b0, byteC});
		addOp(opRead, uartPkg::addrTxFlag, '0, 32'd0);
		addOp(opRead, uartPkg::addrTxFlag, '0, 32'd0);

		repeat (3) @(negedge clock);
		reset = 1'b0;
		@(negedge clock);

		for (int i = 0; i < opTable.size(); i++) begin
			entry = opTable[i];
			case (entry.kind)
				opWrite: begin
					busWrite(entry.address, entry.writeData);
					if (entry.address == uartPkg::addrTxData) begin
						txShadow = entry.writeData[7:0]; // Only the low byte goes on the line
					end else if (entry.address == uartPkg::addrBaudRate) begin
						lineDivisor = entry.writeData[15:0];
					end
				end
				opRead: begin
					busRead(entry.address, value);
					checkValue(value, entry.expected, $sformatf("Register %h", entry.address));
				end
				default: begin
					pollUntil(entry.address, entry.expected);
				end
			endcase
			if (i == opTable.size() - 1 || opTable[i + 1].behavior != entry.behavior) begin
				reportBehavior(entry.behavior);
			end
		end

		$display("Behaviors passed %0d, failed %0d, errors %0d", passCount, failCount, errorCount);
		if (errorCount == 0 && failCount == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- vlog.f
design/uartPkg.sv
design/uartRegs.sv
design/baudGen.sv
design/uartTx.sv
design/uartRx.sv
design/uartTop.sv
bench/uartTopTb.sv

//--- Bender.yml
package:
  name: uart

sources:
  - design/uartPkg.sv
  - design/uartRegs.sv
  - design/baudGen.sv
  - design/uartTx.sv
  - design/uartRx.sv
  - design/uartTop.sv
  - target: test
    files:
      - bench/uartTopTb.sv
